// File: list.f
rtl/acc_pkg.sv
rtl/fifo_if.sv
rtl/shift_fifo.sv
rtl/acc_engine.sv
rtl/acc_unit.sv
tests/acc_unit_properties.sv
tests/acc_unit_tb.sv

// File: tests/acc_unit_tb.sv
//----------------------------------------------------------
// random commands into acc_unit checked against a cycle model
// model queues and acc compared on every falling edge
//----------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module acc_unit_tb;

  localparam int DEPTH  = 4;
  localparam int DATA_W = 16;

  logic                       clk;
  logic                       rst;
  logic                       cmd_wr;
  acc_pkg::opcode_e           cmd_op;
  logic [DATA_W-1:0]          cmd_operand;
  logic                       cmd_full;
  logic                       cmd_fail;
  logic [$clog2(DEPTH+1)-1:0] cmd_cnt;
  logic                       res_rd;
  logic [DATA_W-1:0]          res_data;
  logic                       res_empty;
  logic                       res_fail;
  logic [DATA_W-1:0]          acc;

  // model state
  acc_pkg::opcode_e  cq_op[$];
  logic [DATA_W-1:0] cq_val[$];
  logic [DATA_W-1:0] res_model[$];
  logic [DATA_W-1:0] acc_model;
  logic [31:0]       rng_state;

  acc_unit #(
    .DEPTH  (DEPTH),
    .DATA_W (DATA_W)
  ) UUT (
    .clk         (clk),
    .rst         (rst),
    .cmd_wr      (cmd_wr),
    .cmd_op      (cmd_op),
    .cmd_operand (cmd_operand),
    .cmd_full    (cmd_full),
    .cmd_fail    (cmd_fail),
    .cmd_cnt     (cmd_cnt),
    .res_rd      (res_rd),
    .res_data    (res_data),
    .res_empty   (res_empty),
    .res_fail    (res_fail),
    .acc         (acc)
  );

  always #5 clk = ~clk;

  //----------------------------------------------------------
  // helpers
  //----------------------------------------------------------

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    s = s ^ (s << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    return s;
  endfunction

  task automatic stop_run();
    $display("TB FAILED");
    $fatal(1, "run stopped at first error");
  endtask

  task automatic check_data(input string name, input logic [DATA_W-1:0] got,
                            input logic [DATA_W-1:0] exp);
    if (got !== exp) begin
      $display("[ERROR] %s got %h expected %h", name, got, exp);
      stop_run();
    end
  endtask

  task automatic check_op(input string name, input acc_pkg::opcode_e got,
                          input acc_pkg::opcode_e exp);
    if (got !== exp) begin
      $display("[ERROR] %s got %h expected %h", name, got, exp);
      stop_run();
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("[ERROR] %s got %h expected %h", name, got, exp);
      stop_run();
    end
  endtask

  // one cycle of stimulus 1 ns after the edge
  task automatic drive(input logic wr, input acc_pkg::opcode_e op,
                       input logic [DATA_W-1:0] val, input logic rd);
    @(posedge clk);
    #1;
    cmd_wr      = wr;
    cmd_op      = op;
    cmd_operand = val;
    res_rd      = rd;
  endtask

  //----------------------------------------------------------
  // cycle model that compares then steps
  //----------------------------------------------------------

  task automatic step_model();
    acc_pkg::opcode_e  head;
    logic              pop_ok;
    logic              rd_ok;
    logic              wr_ok;
    logic [DATA_W-1:0] exp_head;
    head     = acc_pkg::OP_CLR;
    exp_head = '0;
    if (cq_op.size() > 0) head = cq_op[0];
    if (res_model.size() > 0) exp_head = res_model[0];
    // STORE waits for room while everything else flows
    pop_ok = (cq_op.size() > 0) &&
             !(head == acc_pkg::OP_STORE && res_model.size() == DEPTH);
    rd_ok  = res_rd && (res_model.size() > 0);
    // full queue takes a write only when a pop frees a slot
    wr_ok  = cmd_wr && (cq_op.size() < DEPTH || pop_ok);

    check_flag("res_empty", res_empty, res_model.size() == 0);
    check_flag("cmd_full", cmd_full, cq_op.size() == DEPTH);
    check_flag("cmd_fail", cmd_fail, cmd_wr && !wr_ok);
    check_flag("res_fail", res_fail, res_rd && res_model.size() == 0);
    check_data("cmd_cnt", DATA_W'(cmd_cnt), DATA_W'(cq_op.size()));
    check_data("acc", acc, acc_model);
    check_data("res_data", res_data, exp_head);
    if (cq_op.size() > 0) check_op("head_op", UUT.engine.head_op, head);

    if (rd_ok) begin
      void'(res_model.pop_front());
    end
    if (pop_ok) begin
      case (head)
        acc_pkg::OP_CLR:   acc_model = '0;
        acc_pkg::OP_LOAD:  acc_model = cq_val[0];
        acc_pkg::OP_ADD:   acc_model = acc_model + cq_val[0];
        acc_pkg::OP_SUB:   acc_model = acc_model - cq_val[0];
        acc_pkg::OP_XOR:   acc_model = acc_model ^ cq_val[0];
        acc_pkg::OP_STORE: res_model.push_back(acc_model);
        default:           acc_model = acc_model;
      endcase
      void'(cq_op.pop_front());
      void'(cq_val.pop_front());
    end
    if (wr_ok) begin
      cq_op.push_back(cmd_op);
      cq_val.push_back(cmd_operand);
    end
  endtask

  always @(negedge clk) begin
    if (rst) begin
      cq_op.delete();
      cq_val.delete();
      res_model.delete();
      acc_model = '0;
    end else begin
      step_model();
    end
  end

  //----------------------------------------------------------
  // bounded waits
  //----------------------------------------------------------

  task automatic wait_cmd_full();
    int t;
    t = 0;
    while (!cmd_full) begin
      @(negedge clk);
      t++;
      if (t > 40) begin
        $display("timeout: command queue never became full");
        stop_run();
      end
    end
  endtask

  task automatic wait_drained();
    int t;
    t = 0;
    while (!(res_empty && cmd_cnt == 0)) begin
      @(negedge clk);
      t++;
      if (t > 60) begin
        $display("timeout: queues did not drain");
        stop_run();
      end
    end
  endtask

  //----------------------------------------------------------
  // stimulus
  //----------------------------------------------------------

  initial begin
    clk         = 1'b0;
    rst         = 1'b1;
    cmd_wr      = 1'b0;
    cmd_op      = acc_pkg::OP_CLR;
    cmd_operand = '0;
    res_rd      = 1'b0;
    acc_model   = '0;
    rng_state   = 32'hbb9a_0b8c;

    repeat (4) @(posedge clk);
    #1;
    rst = 1'b0;

    // reset state
    @(negedge clk);
    check_flag("res_empty", res_empty, 1'b1);
    check_flag("cmd_full", cmd_full, 1'b0);
    check_flag("cmd_fail", cmd_fail, 1'b0);
    check_flag("res_fail", res_fail, 1'b0);
    check_data("cmd_cnt", DATA_W'(cmd_cnt), '0);
    check_data("acc", acc, '0);

    // random arithmetic with the consumer always reading
    // opcode field covers the unused codes too
    for (int i = 0; i < 300; i++) begin
      rng_state = xorshift32(rng_state);
      drive(rng_state[0] | rng_state[1], acc_pkg::opcode_e'(rng_state[4:2]),
            rng_state[31:16], 1'b1);
    end
    drive(1'b0, acc_pkg::OP_CLR, '0, 1'b1);
    wait_drained();

    // back-pressure with the consumer idle so stores pile up
    drive(1'b1, acc_pkg::OP_LOAD, 16'h1234, 1'b0);
    for (int i = 0; i < 12; i++) begin
      drive(1'b1, acc_pkg::OP_STORE, '0, 1'b0);
    end
    drive(1'b0, acc_pkg::OP_CLR, '0, 1'b0);
    wait_cmd_full();
    check_data("cmd_cnt", DATA_W'(cmd_cnt), DATA_W'(DEPTH));

    // overflow load that must vanish
    drive(1'b1, acc_pkg::OP_LOAD, 16'hdead, 1'b0);
    @(negedge clk);
    check_flag("cmd_fail", cmd_fail, 1'b1);
    drive(1'b0, acc_pkg::OP_CLR, '0, 1'b1);
    wait_drained();
    drive(1'b1, acc_pkg::OP_STORE, '0, 1'b0);
    drive(1'b0, acc_pkg::OP_CLR, '0, 1'b1);
    wait_drained();

    // underflow on the drained result queue
    drive(1'b0, acc_pkg::OP_CLR, '0, 1'b1);
    @(negedge clk);
    check_flag("res_fail", res_fail, 1'b1);
    check_flag("res_empty", res_empty, 1'b1);
    check_data("res_data", res_data, '0);

    // store bursts with random reads including empty-queue overlap
    for (int i = 0; i < 300; i++) begin
      rng_state = xorshift32(rng_state);
      drive(rng_state[1] | rng_state[2],
            rng_state[0] ? acc_pkg::OP_STORE : acc_pkg::OP_ADD,
            rng_state[31:16], rng_state[3]);
    end
    drive(1'b0, acc_pkg::OP_CLR, '0, 1'b1);
    wait_drained();

    $display("TB PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// File: tests/acc_unit_properties.sv
//----------------------------------------------------------
// queue and engine properties bound into every acc_unit
//----------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module acc_unit_properties #(
  parameter int DEPTH  = 4
) (
  input logic                       clk,
  input logic                       rst,
  input logic                       cmd_full,
  input logic                       cmd_empty,
  input logic [$clog2(DEPTH+1)-1:0] cmd_cnt,
  input logic                       res_full,
  input logic                       res_empty,
  input logic [$clog2(DEPTH+1)-1:0] res_cnt,
  input logic                       res_w_req
);

  // full and empty are exclusive for depth 2 and up
  assert property (@(posedge clk) disable iff (rst) !(cmd_full && cmd_empty))
    else $error("command queue full and empty together");

  assert property (@(posedge clk) disable iff (rst) !(res_full && res_empty))
    else $error("result queue full and empty together");

  // occupancy bounded by depth
  assert property (@(posedge clk) disable iff (rst) cmd_cnt <= DEPTH)
    else $error("command queue count above depth");

  assert property (@(posedge clk) disable iff (rst) res_cnt <= DEPTH)
    else $error("result queue count above depth");

  // engine stalls a STORE rather than pushing into a full queue
  assert property (@(posedge clk) disable iff (rst) !(res_w_req && res_full))
    else $error("engine wrote the result queue while full");

endmodule

bind acc_unit acc_unit_properties #(
  .DEPTH  (DEPTH)
) props (
  .clk       (clk),
  .rst       (rst),
  .cmd_full  (cmd_q.full),
  .cmd_empty (cmd_q.empty),
  .cmd_cnt   (cmd_q.cnt),
  .res_full  (res_q.full),
  .res_empty (res_q.empty),
  .res_cnt   (res_q.cnt),
  .res_w_req (res_q.w_req)
);

`default_nettype wire

// File: rtl/acc_unit.sv
//----------------------------------------------------------
// accumulator unit top: command queue, engine, result queue
// producer writes commands, consumer pops STORE results
//----------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module acc_unit #(
  parameter int DEPTH  = acc_pkg::DEPTH_DEF,
  parameter int DATA_W = acc_pkg::DATA_W_DEF
) (
  input  logic                         clk,
  input  logic                         rst,

  // command producer side
  input  logic                         cmd_wr,
  input  acc_pkg::opcode_e             cmd_op,
  input  logic [DATA_W-1:0]            cmd_operand,
  output logic                         cmd_full,
  output logic                         cmd_fail,
  output logic [$clog2(DEPTH+1)-1:0]   cmd_cnt,

  // result consumer side
  input  logic                         res_rd,
  output logic [DATA_W-1:0]            res_data,
  output logic                         res_empty,
  output logic                         res_fail,

  // live accumulator value
  output logic [DATA_W-1:0]            acc
);

  localparam int CMD_W = DATA_W + acc_pkg::OP_W;

  //----------------------------------------------------------
  // queue bundles
  //----------------------------------------------------------

  fifo_if #(.WIDTH(CMD_W),  .DEPTH(DEPTH)) cmd_q ();
  fifo_if #(.WIDTH(DATA_W), .DEPTH(DEPTH)) res_q ();

  // producer ports write the command queue
  assign cmd_q.w_req  = cmd_wr;
  assign cmd_q.w_data = {cmd_op, cmd_operand};
  assign cmd_full     = cmd_q.full;
  assign cmd_fail     = cmd_q.fail;
  assign cmd_cnt      = cmd_q.cnt;

  // consumer ports read the result queue
  assign res_q.r_req = res_rd;
  assign res_data    = res_q.r_data;
  assign res_empty   = res_q.empty;
  assign res_fail    = res_q.fail;

  //----------------------------------------------------------
  // queues
  //----------------------------------------------------------

  shift_fifo #(
    .DEPTH (DEPTH),
    .WIDTH (CMD_W)
  ) cmd_fifo (
    .clk (clk),
    .rst (rst),
    .q   (cmd_q.queue)
  );

  shift_fifo #(
    .DEPTH (DEPTH),
    .WIDTH (DATA_W)
  ) res_fifo (
    .clk (clk),
    .rst (rst),
    .q   (res_q.queue)
  );

  //----------------------------------------------------------
  // engine, reader of cmd_q and sole writer of res_q
  //----------------------------------------------------------

  acc_engine #(
    .DATA_W (DATA_W)
  ) engine (
    .clk (clk),
    .rst (rst),
    .cmd (cmd_q.reader),
    .res (res_q.writer),
    .acc (acc)
  );

endmodule

`default_nettype wire

// File: rtl/acc_engine.sv
//----------------------------------------------------------
// command executor between the command and result queues
// pops the head in order, updates acc, pushes STORE results
//----------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module acc_engine #(
  parameter int DATA_W = 16
) (
  input  logic              clk,
  input  logic              rst,
  fifo_if.reader            cmd,
  fifo_if.writer            res,
  output logic [DATA_W-1:0] acc
);

  // command word is {opcode, operand}
  localparam int CMD_W = DATA_W + acc_pkg::OP_W;

  //----------------------------------------------------------
  // head decode
  //----------------------------------------------------------

  // fields of the command at the head of the queue
  acc_pkg::opcode_e  head_op;
  logic [DATA_W-1:0] head_operand;

  // pop control
  logic is_store;
  logic stall;
  logic pop;

  // accumulator and its next value
  logic [DATA_W-1:0] acc_r;
  logic [DATA_W-1:0] acc_next;

  // opcode from the top bits, operand below it
  // head reads zero while empty, gated by pop below
  assign head_op      = acc_pkg::opcode_e'(cmd.r_data[CMD_W-1:DATA_W]);
  assign head_operand = cmd.r_data[DATA_W-1:0];

  assign is_store = (head_op == acc_pkg::OP_STORE);

  //----------------------------------------------------------
  // pop and stall
  //----------------------------------------------------------

  // only a STORE needs room in the result queue
  // other opcodes keep flowing while results back up
  assign stall = is_store && res.full;

  // decision in the same cycle the head shows up
  assign pop = !cmd.empty && !stall;

  assign cmd.r_req = pop;

  // STORE result goes out with the pop
  // acc value before this edge's update
  assign res.w_req  = pop && is_store;
  assign res.w_data = acc_r;

  //----------------------------------------------------------
  // opcode execution
  //----------------------------------------------------------

  always_comb begin
    // unused codes and STORE leave acc alone
    acc_next = acc_r;
    case (head_op)
      acc_pkg::OP_CLR: begin
        acc_next = '0;
      end
      acc_pkg::OP_LOAD: begin
        acc_next = head_operand;
      end
      acc_pkg::OP_ADD: begin
        // wraps, no carry kept
        acc_next = acc_r + head_operand;
      end
      acc_pkg::OP_SUB: begin
        // wraps, no borrow kept
        acc_next = acc_r - head_operand;
      end
      acc_pkg::OP_XOR: begin
        acc_next = acc_r ^ head_operand;
      end
      acc_pkg::OP_STORE: begin
        acc_next = acc_r;
      end
      default: begin
        acc_next = acc_r;
      end
    endcase
  end

  //----------------------------------------------------------
  // accumulator register
  //----------------------------------------------------------

  // update at the edge ending the pop cycle
  always_ff @(posedge clk) begin
    if (rst) begin
      acc_r <= '0;
    end else if (pop) begin
      acc_r <= acc_next;
    end
  end

  assign acc = acc_r;

endmodule

`default_nettype wire

// File: rtl/shift_fifo.sv
//----------------------------------------------------------
// single-clock first-word-fall-through queue on a shift register
// head always at slot 0, status flags decoded from the count
//----------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module shift_fifo #(
  parameter int DEPTH = 4,
  parameter int WIDTH = 16
) (
  input  logic    clk,
  input  logic    rst,
  fifo_if.queue   q
);

  localparam int CNT_W = $clog2(DEPTH+1);

  // storage, slot 0 is the oldest entry
  logic [DEPTH-1:0][WIDTH-1:0] data;

  // number of valid slots
  logic [CNT_W-1:0] cnt;

  logic empty;
  logic full;

  // accepted requests this cycle
  logic rd_ok;
  logic wr_ok;

  // slot the incoming word lands in
  logic [CNT_W-1:0] wr_idx;

  //----------------------------------------------------------
  // request decode
  //----------------------------------------------------------

  assign empty = (cnt == '0);
  assign full  = (cnt == CNT_W'(DEPTH));

  // nothing to read when empty
  assign rd_ok = q.r_req && !empty;

  // full queue still takes a word if one leaves this cycle
  // empty queue with read and write keeps the write
  assign wr_ok = q.w_req && (!full || rd_ok);

  // shift moves everything down one slot on a read
  assign wr_idx = rd_ok ? cnt - 1'b1 : cnt;

  //----------------------------------------------------------
  // storage shift and write
  //----------------------------------------------------------

  always_ff @(posedge clk) begin
    for (int i = 0; i < DEPTH; i++) begin
      // shift toward the head on a read
      if (rd_ok && i < DEPTH-1) begin
        data[i] <= data[i+1];
      end
      // new word overrides the shifted value in its slot
      if (wr_ok && wr_idx == CNT_W'(i)) begin
        data[i] <= q.w_data;
      end
    end
  end

  //----------------------------------------------------------
  // occupancy count
  //----------------------------------------------------------

  always_ff @(posedge clk) begin
    if (rst) begin
      cnt <= '0;
    end else begin
      case ({wr_ok, rd_ok})
        2'b10:   cnt <= cnt + 1'b1;
        2'b01:   cnt <= cnt - 1'b1;
        // read and write together, count holds
        default: cnt <= cnt;
      endcase
    end
  end

  //----------------------------------------------------------
  // outputs
  //----------------------------------------------------------

  // fwft head, zero while empty
  assign q.r_data = empty ? '0 : data[0];

  assign q.cnt   = cnt;
  assign q.empty = empty;
  assign q.full  = full;

  // one-cycle flag for a refused request
  // write refused only if full and no read frees a slot
  assign q.fail = (q.r_req && empty) ||
                  (q.w_req && full && !rd_ok);

endmodule

`default_nettype wire

// File: rtl/fifo_if.sv
//----------------------------------------------------------
// signal bundle for one queue: write side, read side, status
// queue, writer and reader each connect through a modport
//----------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

interface fifo_if #(
  parameter int WIDTH = 16,
  parameter int DEPTH = 4
);

  // write side
  logic                         w_req;
  logic [WIDTH-1:0]             w_data;

  // read side, head shown without a request
  logic                         r_req;
  logic [WIDTH-1:0]             r_data;

  // status, cnt spans 0..DEPTH
  logic [$clog2(DEPTH+1)-1:0]   cnt;
  logic                         empty;
  logic                         full;
  logic                         fail;

  modport queue  (input w_req, w_data, r_req,
                  output r_data, cnt, empty, full, fail);

  modport writer (output w_req, w_data,
                  input cnt, full, fail);

  modport reader (output r_req,
                  input r_data, cnt, empty, fail);

endinterface

`default_nettype wire

// File: rtl/acc_pkg.sv
//----------------------------------------------------------
// shared opcodes and default sizes for the accumulator unit
// referenced by scoped names from the rtl and the testbench
//----------------------------------------------------------

`default_nettype none

package acc_pkg;

  //----------------------------------------------------------
  // default sizes
  //----------------------------------------------------------

  // operand and accumulator width
  localparam int DATA_W_DEF = 16;

  // queue depth, any value from 2 up
  localparam int DEPTH_DEF = 4;

  // opcode field width, top bits of a command word
  localparam int OP_W = 3;

  //----------------------------------------------------------
  // command opcodes
  //----------------------------------------------------------

  // codes 6 and 7 unused, consumed with no effect
  typedef enum logic [OP_W-1:0] {
    OP_CLR   = 3'd0,  // acc to zero
    OP_LOAD  = 3'd1,  // acc takes operand
    OP_ADD   = 3'd2,  // wrap-around add
    OP_SUB   = 3'd3,  // wrap-around subtract
    OP_XOR   = 3'd4,  // bitwise xor
    OP_STORE = 3'd5   // push acc to result queue
  } opcode_e;

endpackage

`default_nettype wire
